//--- wb_cache.f
common/cache_pkg.sv
cache/cache_ram.sv
cache/cache_lookup.sv
cache/cache_refill.sv
cache/cache_respond.sv
verilog/wb_cache.sv
testbench/wb_cache_props.sv
testbench/tb_wb_cache.sv

//--- run.sh
#!/bin/bash
# build with Verilator, then run; the exit status is the simulator's
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_wb_cache \
	-f wb_cache.f -o tb_wb_cache &&
./obj_dir/tb_wb_cache ||
{ echo "simulation failed"; exit 1; }
exit 0

//--- testbench/tb_wb_cache.sv
`timescale 1ns/100ps

module tb_wb_cache
	import cache_pkg::*;
();

	localparam int PERIOD = 20;
	localparam int DRIVE_DELAY = 1;
	localparam int ROWS = 25;
	localparam int MEM_WORDS = 1 << ADDR_W;
	localparam int BYTE_W = DATA_W / SEL_W;

	// we, address, byte select, write data, expected read data, miss, write-back, victim line
	typedef struct packed {
		logic we;
		logic [ADDR_W-1:0] adr;
		logic [SEL_W-1:0] sel;
		logic [DATA_W-1:0] dat_w;
		logic [DATA_W-1:0] exp_rd;
		logic miss;
		logic wb;
		logic [ADDR_W-1:0] wb_adr;
	} row_t;

	logic CLK, RESET;
	logic cpu_cyc, cpu_stb, cpu_we, cpu_ack;
	logic [ADDR_W-1:0] cpu_adr, mem_adr;
	logic [SEL_W-1:0] cpu_sel;
	logic [DATA_W-1:0] cpu_dat_w, cpu_dat_r, mem_dat_w, mem_dat_r;
	logic mem_cyc, mem_stb, mem_we, mem_ack;

	row_t rows [ROWS];
	logic [DATA_W-1:0] mem_image [MEM_WORDS];
	logic [DATA_W-1:0] shadow [MEM_WORDS];
	logic [ADDR_W-1:0] cur_adr, cur_wb_adr;
	logic [1:0] wait_cnt;
	int read_beats, write_beats;
	integer seed = 52;

	wb_cache dut (.*);

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "run stopped on first error");
	endtask

	// bit 16 folds into the top data bit
	task automatic init_memory();
		logic [ADDR_W-1:0] a;
		for (int i = 0; i < MEM_WORDS; i++) begin
			a = ADDR_W'(i);
			mem_image[a] = a[DATA_W-1:0] ^ 16'hA5A5 ^ {a[ADDR_W-1], 15'b0};
			shadow[a] = mem_image[a];
		end
	endtask

	task automatic load_table();
		// read miss, repeat hit, byte and word writes on set 5
		rows[0] = '{1'b0, 17'h0022A, 2'b11, 16'h0000, 16'hA78F, 1'b1, 1'b0, 17'h0};
		rows[1] = '{1'b0, 17'h0022A, 2'b11, 16'h0000, 16'hA78F, 1'b0, 1'b0, 17'h0};
		rows[2] = '{1'b1, 17'h0022B, 2'b01, 16'h1234, 16'h0000, 1'b0, 1'b0, 17'h0};
		rows[3] = '{1'b0, 17'h0022B, 2'b11, 16'h0000, 16'hA734, 1'b0, 1'b0, 17'h0};
		rows[4] = '{1'b1, 17'h0022C, 2'b11, 16'hBEEF, 16'h0000, 1'b0, 1'b0, 17'h0};
		rows[5] = '{1'b0, 17'h0022C, 2'b11, 16'h0000, 16'hBEEF, 1'b0, 1'b0, 17'h0};
		rows[6] = '{1'b1, 17'h0022D, 2'b10, 16'h5566, 16'h0000, 1'b0, 1'b0, 17'h0};
		rows[7] = '{1'b0, 17'h0022D, 2'b11, 16'h0000, 16'h5588, 1'b0, 1'b0, 17'h0};
		// lru on set 9
		rows[8] = '{1'b0, 17'h02048, 2'b11, 16'h0000, 16'h85ED, 1'b1, 1'b0, 17'h0};
		rows[9] = '{1'b0, 17'h02249, 2'b11, 16'h0000, 16'h87EC, 1'b1, 1'b0, 17'h0};
		rows[10] = '{1'b0, 17'h02048, 2'b11, 16'h0000, 16'h85ED, 1'b0, 1'b0, 17'h0};
		rows[11] = '{1'b0, 17'h0244A, 2'b11, 16'h0000, 16'h81EF, 1'b1, 1'b0, 17'h0};
		rows[12] = '{1'b0, 17'h02048, 2'b11, 16'h0000, 16'h85ED, 1'b0, 1'b0, 17'h0};
		rows[13] = '{1'b0, 17'h02249, 2'b11, 16'h0000, 16'h87EC, 1'b1, 1'b0, 17'h0};
		// dirty victim in set 5 goes back to memory
		rows[14] = '{1'b0, 17'h00428, 2'b11, 16'h0000, 16'hA18D, 1'b1, 1'b0, 17'h0};
		rows[15] = '{1'b0, 17'h00628, 2'b11, 16'h0000, 16'hA38D, 1'b1, 1'b1, 17'h00228};
		rows[16] = '{1'b0, 17'h0022B, 2'b11, 16'h0000, 16'hA734, 1'b1, 1'b0, 17'h0};
		rows[17] = '{1'b0, 17'h0022C, 2'b11, 16'h0000, 16'hBEEF, 1'b0, 1'b0, 17'h0};
		rows[18] = '{1'b0, 17'h0022D, 2'b11, 16'h0000, 16'h5588, 1'b0, 1'b0, 17'h0};
		// write allocate on set 20
		rows[19] = '{1'b1, 17'h060A3, 2'b01, 16'h00C3, 16'h0000, 1'b1, 1'b0, 17'h0};
		rows[20] = '{1'b0, 17'h060A3, 2'b11, 16'h0000, 16'hC5C3, 1'b0, 1'b0, 17'h0};
		rows[21] = '{1'b0, 17'h060A4, 2'b11, 16'h0000, 16'hC501, 1'b0, 1'b0, 17'h0};
		rows[22] = '{1'b0, 17'h1E0A1, 2'b11, 16'h0000, 16'hC504, 1'b1, 1'b0, 17'h0};
		rows[23] = '{1'b0, 17'h062A0, 2'b11, 16'h0000, 16'hC705, 1'b1, 1'b1, 17'h060A0};
		rows[24] = '{1'b0, 17'h060A3, 2'b11, 16'h0000, 16'hC5C3, 1'b1, 1'b0, 17'h0};
	endtask

	task automatic serve_beat();
		logic [ADDR_W-1:0] exp_adr;
		if (mem_we) begin
			exp_adr = {cur_wb_adr[ADDR_W-1:OFFSET_W], OFFSET_W'(write_beats)};
			assert (read_beats == 0) else stop_run("write-back beat came after a fetch beat");
			assert (mem_adr == exp_adr)
				else stop_run($sformatf("Fail mem_adr got %h expected %h", mem_adr, exp_adr));
			mem_image[mem_adr] = mem_dat_w;
			write_beats++;
		end else begin
			exp_adr = {cur_adr[ADDR_W-1:OFFSET_W], OFFSET_W'(read_beats)};
			assert (mem_adr == exp_adr)
				else stop_run($sformatf("Fail mem_adr got %h expected %h", mem_adr, exp_adr));
			mem_dat_r = mem_image[mem_adr];
			read_beats++;
		end
	endtask

	task automatic check_written_line(input logic [ADDR_W-1:0] base);
		logic [ADDR_W-1:0] a;
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			a = {base[ADDR_W-1:OFFSET_W], OFFSET_W'(w)};
			assert (mem_image[a] == shadow[a])
				else stop_run($sformatf("Fail mem_image[%h] got %h expected %h",
					a, mem_image[a], shadow[a]));
		end
	endtask

	task automatic run_row(input row_t row);
		int cycles;
		int exp_reads;
		int exp_writes;
		cur_adr = row.adr;
		cur_wb_adr = row.wb_adr;
		read_beats = 0;
		write_beats = 0;
		cycles = 0;
		exp_reads = row.miss ? 8 : 0;
		exp_writes = row.wb ? 8 : 0;
		cpu_cyc = 1'b1;
		cpu_stb = 1'b1;
		cpu_we = row.we;
		cpu_adr = row.adr;
		cpu_sel = row.sel;
		cpu_dat_w = row.dat_w;
		do begin
			@(posedge CLK);
			#DRIVE_DELAY;
			cycles++;
		end while (!cpu_ack);
		if (row.we) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (row.sel[b]) begin
					shadow[row.adr][b*BYTE_W +: BYTE_W] = row.dat_w[b*BYTE_W +: BYTE_W];
				end
			end
		end else begin
			assert (cpu_dat_r == row.exp_rd)
				else stop_run($sformatf("Fail cpu_dat_r at %h got %h expected %h",
					row.adr, cpu_dat_r, row.exp_rd));
		end
		assert (read_beats == exp_reads)
			else stop_run($sformatf("Fail read_beats at %h got %h expected %h",
				row.adr, read_beats, exp_reads));
		assert (write_beats == exp_writes)
			else stop_run($sformatf("Fail write_beats at %h got %h expected %h",
				row.adr, write_beats, exp_writes));
		if (!row.miss) begin
			assert (cycles == 3)
				else stop_run($sformatf("Fail cpu_ack latency got %h expected %h", cycles, 3));
		end
		if (row.wb) begin
			check_written_line(row.wb_adr);
		end
		// hold the request over the edge that samples cpu_ack
		@(posedge CLK);
		#DRIVE_DELAY;
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		cpu_we = 1'b0;
		@(posedge CLK);
		#DRIVE_DELAY;
	endtask

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	// memory model acks each beat after 0 to 3 idle cycles
	initial begin
		logic [31:0] r;
		mem_ack = 1'b0;
		mem_dat_r = '0;
		r = $random(seed);
		wait_cnt = r[1:0];
		forever begin
			@(posedge CLK);
			#DRIVE_DELAY;
			if (mem_ack) begin
				mem_ack = 1'b0;
				r = $random(seed);
				wait_cnt = r[1:0];
			end else if (mem_stb && !RESET) begin
				if (wait_cnt != 2'd0) begin
					wait_cnt = wait_cnt - 2'd1;
				end else begin
					serve_beat();
					mem_ack = 1'b1;
				end
			end
		end
	end

	initial begin
		repeat ((ROWS + 1) * 100) @(posedge CLK);
		stop_run("watchdog expired before all table rows completed");
	end

	initial begin
		RESET = 1'b1;
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
		cpu_we = 1'b0;
		cpu_adr = '0;
		cpu_sel = '0;
		cpu_dat_w = '0;
		init_memory();
		load_table();
		repeat (3) @(posedge CLK);
		#DRIVE_DELAY;
		RESET = 1'b0;
		repeat (5) begin
			@(posedge CLK);
			#DRIVE_DELAY;
			assert (!cpu_ack && !mem_cyc) else stop_run("bus activity while idle after reset");
		end
		for (int i = 0; i < ROWS; i++) begin
			run_row(rows[i]);
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

//--- testbench/wb_cache_props.sv
`timescale 1ns/100ps

module wb_cache_props
	import cache_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic cpu_cyc,
	input logic cpu_stb,
	input logic cpu_ack,
	input logic mem_cyc,
	input logic mem_stb,
	input logic mem_ack,
	input logic mem_we,
	input logic [ADDR_W-1:0] mem_adr
);

	ack_in_cycle: assert property (@(posedge CLK) disable iff (RESET)
		cpu_ack |-> (cpu_cyc && cpu_stb))
		else $error("cpu_ack raised outside a cpu bus cycle");

	ack_single: assert property (@(posedge CLK) disable iff (RESET)
		cpu_ack |=> !cpu_ack)
		else $error("cpu_ack high for two cycles in a row");

	// a line transfer ends only on an acked beat
	cyc_ends_on_ack: assert property (@(posedge CLK) disable iff (RESET)
		$fell(mem_cyc) |-> $past(mem_ack))
		else $error("mem_cyc dropped before the last beat was acked");

	// beat held until the memory acks it
	beat_held: assert property (@(posedge CLK) disable iff (RESET)
		(mem_stb && !mem_ack) |=> ($stable(mem_adr) && $stable(mem_we)))
		else $error("mem_adr or mem_we changed before mem_ack");

endmodule

bind wb_cache wb_cache_props props (
	.CLK(CLK),
	.RESET(RESET),
	.cpu_cyc(cpu_cyc),
	.cpu_stb(cpu_stb),
	.cpu_ack(cpu_ack),
	.mem_cyc(mem_cyc),
	.mem_stb(mem_stb),
	.mem_ack(mem_ack),
	.mem_we(mem_we),
	.mem_adr(mem_adr)
);

//--- verilog/wb_cache.sv
`timescale 1ns/100ps

module wb_cache
	import cache_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic cpu_cyc,
	input logic cpu_stb,
	input logic cpu_we,
	input logic [ADDR_W-1:0] cpu_adr,
	input logic [SEL_W-1:0] cpu_sel,
	input logic [DATA_W-1:0] cpu_dat_w,
	output logic [DATA_W-1:0] cpu_dat_r,
	output logic cpu_ack,
	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we,
	output logic [ADDR_W-1:0] mem_adr,
	output logic [DATA_W-1:0] mem_dat_w,
	input logic [DATA_W-1:0] mem_dat_r,
	input logic mem_ack
);

	set_state_t set_state;
	set_lines_t set_lines;
	logic lk_valid, lk_we, lk_hit, lk_way;
	logic [ADDR_W-1:0] lk_adr;
	logic [SEL_W-1:0] lk_sel;
	logic [DATA_W-1:0] lk_dat;
	set_state_t lk_state;
	logic rf_valid, rf_we, rf_way, rf_fill;
	logic [ADDR_W-1:0] rf_adr;
	logic [SEL_W-1:0] rf_sel;
	logic [DATA_W-1:0] rf_dat;
	set_state_t rf_state;
	line_t rf_line;
	logic state_we, line_we, done;
	set_state_t state_wdata;
	set_lines_t line_wdata;
	logic [SET_W-1:0] wr_set;

	cache_lookup lookup (.*);
	cache_refill refill (.*);
	cache_respond respond (.*);

	// tags, valid, dirty and lru per set
	cache_ram #(.DEPTH(SETS), .entry_t(set_state_t)) state_ram (.CLK(CLK), .RESET(RESET),
		.rd_idx(addr_set(cpu_adr)), .rd_data(set_state), .we(state_we), .wr_idx(wr_set),
		.wr_data(state_wdata));

	cache_ram #(.DEPTH(SETS), .entry_t(set_lines_t)) line_ram (.CLK(CLK), .RESET(RESET),
		.rd_idx(addr_set(cpu_adr)), .rd_data(set_lines), .we(line_we), .wr_idx(wr_set),
		.wr_data(line_wdata));

endmodule

//--- cache/cache_respond.sv
`timescale 1ns/100ps

module cache_respond
	import cache_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic rf_valid,
	input logic rf_we,
	input logic [ADDR_W-1:0] rf_adr,
	input logic [SEL_W-1:0] rf_sel,
	input logic [DATA_W-1:0] rf_dat,
	input logic rf_way,
	input logic rf_fill,
	input set_state_t rf_state,
	input line_t rf_line,
	input set_lines_t set_lines,
	output logic state_we,
	output set_state_t state_wdata,
	output logic line_we,
	output set_lines_t line_wdata,
	output logic [SET_W-1:0] wr_set,
	output logic cpu_ack,
	output logic [DATA_W-1:0] cpu_dat_r,
	output logic done
);

	localparam int BYTE_W = DATA_W / SEL_W;

	logic [OFFSET_W-1:0] offset;
	logic [DATA_W-1:0] word;
	line_t merged;

	assign offset = addr_offset(rf_adr);

	// byte merge, a read leaves the word as it is
	always_comb begin
		word = rf_line[offset];
		if (rf_we) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (rf_sel[b]) begin
					word[b*BYTE_W +: BYTE_W] = rf_dat[b*BYTE_W +: BYTE_W];
				end
			end
		end
		merged = rf_line;
		merged[offset] = word;
	end

	always_comb begin
		state_wdata = rf_state;
		if (rf_fill) begin
			state_wdata.ways[rf_way].valid = 1'b1;
			state_wdata.ways[rf_way].tag = addr_tag(rf_adr);
		end
		if (rf_we) begin
			state_wdata.ways[rf_way].dirty = 1'b1;
		end else if (rf_fill) begin
			state_wdata.ways[rf_way].dirty = 1'b0;
		end
		state_wdata.lru = !rf_way;
		// other way keeps its line
		line_wdata = set_lines;
		line_wdata.lines[rf_way] = merged;
	end

	assign state_we = rf_valid;
	assign line_we = rf_valid;
	assign wr_set = addr_set(rf_adr);

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			cpu_ack <= 1'b0;
		end else begin
			cpu_ack <= rf_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (rf_valid) begin
			cpu_dat_r <= word;
		end
	end

	assign done = cpu_ack;

endmodule

//--- cache/cache_refill.sv
`timescale 1ns/100ps

module cache_refill
	import cache_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic lk_valid,
	input logic lk_we,
	input logic [ADDR_W-1:0] lk_adr,
	input logic [SEL_W-1:0] lk_sel,
	input logic [DATA_W-1:0] lk_dat,
	input logic lk_hit,
	input logic lk_way,
	input set_state_t lk_state,
	input set_lines_t set_lines,
	input logic [DATA_W-1:0] mem_dat_r,
	input logic mem_ack,
	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we,
	output logic [ADDR_W-1:0] mem_adr,
	output logic [DATA_W-1:0] mem_dat_w,
	output logic rf_valid,
	output logic rf_we,
	output logic [ADDR_W-1:0] rf_adr,
	output logic [SEL_W-1:0] rf_sel,
	output logic [DATA_W-1:0] rf_dat,
	output logic rf_way,
	output logic rf_fill,
	output set_state_t rf_state,
	output line_t rf_line
);

	typedef enum logic [1:0] {IDLE, WRITE_BACK, TURN, FETCH} state_t;

	state_t state;
	logic [OFFSET_W-1:0] beat;
	way_t victim;
	logic [TAG_W-1:0] line_tag;

	assign victim = lk_state.ways[lk_way];

	// write-back goes to the victim's line, fetch to the request's line
	assign line_tag = (state == WRITE_BACK) ? rf_state.ways[rf_way].tag : addr_tag(rf_adr);
	assign mem_cyc = (state == WRITE_BACK) || (state == FETCH);
	assign mem_stb = mem_cyc;
	assign mem_we = (state == WRITE_BACK);
	assign mem_adr = {line_tag, addr_set(rf_adr), beat};
	assign mem_dat_w = rf_line[beat];

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			state <= IDLE;
			beat <= '0;
			rf_valid <= 1'b0;
		end else begin
			rf_valid <= 1'b0;
			case (state)
				IDLE: begin
					beat <= '0;
					if (lk_valid && lk_hit) begin
						rf_valid <= 1'b1;
					end else if (lk_valid && victim.valid && victim.dirty) begin
						state <= WRITE_BACK;
					end else if (lk_valid) begin
						state <= FETCH;
					end
				end
				WRITE_BACK: begin
					if (mem_ack) begin
						beat <= beat + 1'b1;
						if (&beat) begin
							state <= TURN;
						end
					end
				end
				// one idle cycle between the two bus cycles
				TURN: begin
					state <= FETCH;
				end
				FETCH: begin
					if (mem_ack) begin
						beat <= beat + 1'b1;
						if (&beat) begin
							state <= IDLE;
							rf_valid <= 1'b1;
						end
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// line buffer holds the hit or victim line, then fills beat by beat
	always_ff @(posedge CLK) begin
		if (lk_valid) begin
			rf_we <= lk_we;
			rf_adr <= lk_adr;
			rf_sel <= lk_sel;
			rf_dat <= lk_dat;
			rf_way <= lk_way;
			rf_fill <= !lk_hit;
			rf_state <= lk_state;
			rf_line <= set_lines.lines[lk_way];
		end else if (state == FETCH && mem_ack) begin
			rf_line[beat] <= mem_dat_r;
		end
	end

endmodule

//--- cache/cache_lookup.sv
`timescale 1ns/100ps

module cache_lookup
	import cache_pkg::*;
(
	input logic CLK,
	input logic RESET,
	input logic cpu_cyc,
	input logic cpu_stb,
	input logic cpu_we,
	input logic [ADDR_W-1:0] cpu_adr,
	input logic [SEL_W-1:0] cpu_sel,
	input logic [DATA_W-1:0] cpu_dat_w,
	input logic done,
	input set_state_t set_state,
	output logic lk_valid,
	output logic lk_we,
	output logic [ADDR_W-1:0] lk_adr,
	output logic [SEL_W-1:0] lk_sel,
	output logic [DATA_W-1:0] lk_dat,
	output logic lk_hit,
	output logic lk_way,
	output set_state_t lk_state
);

	logic busy;
	logic accept;
	logic [TAG_W-1:0] req_tag;
	logic [1:0] match;
	logic hit;
	logic way;

	assign req_tag = addr_tag(cpu_adr);
	assign match[0] = set_state.ways[0].valid && (set_state.ways[0].tag == req_tag);
	assign match[1] = set_state.ways[1].valid && (set_state.ways[1].tag == req_tag);
	assign hit = |match;
	assign accept = cpu_cyc && cpu_stb && !busy;

	// hit way, else victim: free way 0, free way 1, then lru
	always_comb begin
		if (match[0]) begin
			way = 1'b0;
		end else if (match[1]) begin
			way = 1'b1;
		end else if (!set_state.ways[0].valid) begin
			way = 1'b0;
		end else if (!set_state.ways[1].valid) begin
			way = 1'b1;
		end else begin
			way = set_state.lru;
		end
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			busy <= 1'b0;
			lk_valid <= 1'b0;
		end else begin
			lk_valid <= accept;
			if (accept) begin
				busy <= 1'b1;
			end else if (done) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			lk_we <= cpu_we;
			lk_adr <= cpu_adr;
			lk_sel <= cpu_sel;
			lk_dat <= cpu_dat_w;
			lk_hit <= hit;
			lk_way <= way;
			lk_state <= set_state;
		end
	end

endmodule

//--- cache/cache_ram.sv
`timescale 1ns/100ps

module cache_ram
	import cache_pkg::*;
#(
	parameter int DEPTH = SETS,
	parameter type entry_t = set_state_t
) (
	input logic CLK,
	input logic RESET,
	input logic [SET_W-1:0] rd_idx,
	output entry_t rd_data,
	input logic we,
	input logic [SET_W-1:0] wr_idx,
	input entry_t wr_data
);

	entry_t mem [DEPTH];

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[wr_idx] <= wr_data;
		end
	end

	// async read, address held by the cpu for the whole request
	assign rd_data = mem[rd_idx];

endmodule

//--- common/cache_pkg.sv
package cache_pkg;

	// bus widths
	localparam int ADDR_W = 17;
	localparam int DATA_W = 16;
	localparam int SEL_W = 2;

	// geometry
	localparam int OFFSET_W = 3;
	localparam int WORDS_PER_LINE = 8;
	localparam int SET_W = 6;
	localparam int SETS = 64;
	localparam int TAG_W = 8;

	typedef logic [WORDS_PER_LINE-1:0][DATA_W-1:0] line_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		logic [TAG_W-1:0] tag;
	} way_t;

	// lru names the way to evict next
	typedef struct packed {
		way_t [1:0] ways;
		logic lru;
	} set_state_t;

	typedef struct packed {
		line_t [1:0] lines;
	} set_lines_t;

	// address is tag, set, offset from the top down
	function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_W-1:0] adr);
		return adr[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic logic [SET_W-1:0] addr_set(input logic [ADDR_W-1:0] adr);
		return adr[OFFSET_W +: SET_W];
	endfunction

	function automatic logic [OFFSET_W-1:0] addr_offset(input logic [ADDR_W-1:0] adr);
		return adr[OFFSET_W-1:0];
	endfunction

endpackage
